//--- px_params.svh
// Sizing for the processor state control unit
// Word width, request buffer depth and bus answer timeout
`ifndef PX_PARAMS_SVH
`define PX_PARAMS_SVH

// Data and address width
`define PX_W 16

// Request buffer entries, 2, 4 or 8
`define PX_FIFO_DEPTH 4

// Cycles allowed between r or w rising and ok
`define PX_ALARM_TICKS 16

`endif

//--- px_pkg.sv
// Shared types of the processor state control unit
// Sequencer states, instruction word views and system bus records
`include "px_params.svh"

package px_pkg;

	// Sequencer control states
	typedef enum logic [2:0] {
		ST_P1,		// Start
		ST_K1,		// Instruction fetch
		ST_K2,		// Decode
		ST_W,		// Memory execute
		ST_HLT,		// Halted
		ST_AWARIA	// Bus alarm
	} px_state_e;

	// Opcodes, everything else is a no-op
	localparam logic [3:0] OP_LI  = 4'd1;
	localparam logic [3:0] OP_AI  = 4'd2;
	localparam logic [3:0] OP_LW  = 4'd3;
	localparam logic [3:0] OP_SW  = 4'd4;
	localparam logic [3:0] OP_HLT = 4'd15;

	// Instruction word, memory reference or short immediate
	typedef union packed {
		struct packed {
			logic [3:0]  op;
			logic [11:0] addr;	// Word address
		} mem;
		struct packed {
			logic [3:0]         op;
			logic signed [11:0] imm;	// Sign extended on use
		} short;
	} px_instr_u;

	typedef struct packed {
		logic             write;	// Set for a posted store
		logic [`PX_W-1:0] addr;
		logic [`PX_W-1:0] data;
	} px_bus_req_t;

	typedef struct packed {
		logic             valid;	// One-cycle pulse
		logic             alarm;	// No answer from memory
		logic [`PX_W-1:0] data;
	} px_bus_resp_t;

	typedef struct packed {
		logic             zg;	// Bus request
		logic             r;
		logic             w;
		logic [`PX_W-1:0] ad;
		logic [`PX_W-1:0] dt_out;
	} px_bus_pins_t;

endpackage

//--- px_req_fifo.sv
`timescale 1ns/1ps
// Request buffer between sequencer and bus master
// Circular buffer keeping posted writes and reads in program order
`include "px_params.svh"

module px_req_fifo import px_pkg::*; (
	input  logic        got,
	input  logic        clo_,
	input  logic        push,
	input  px_bus_req_t din,
	input  logic        pop,
	output px_bus_req_t dout,
	output logic        full,
	output logic        empty
);

	localparam int DEPTH = `PX_FIFO_DEPTH;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	px_bus_req_t   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	assign full    = (count == CW'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full;	// Push ignored while full
	assign do_pop  = pop & ~empty;
	assign dout    = mem[rd_ptr];	// Head visible the cycle after push

	always_ff @(posedge got) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;	// Wrap
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

//--- px_bus.sv
`timescale 1ns/1ps
// System bus master
// Drains the request buffer over the zg/zw/ok bus, one access at a time,
// returns read data and raises an alarm when memory does not answer
`include "px_params.svh"

module px_bus import px_pkg::*; (
	input  logic             got,
	input  logic             clo_,
	input  px_bus_req_t      head,
	input  logic             empty,
	output logic             pop,
	input  logic             zw,
	input  logic             ok,
	input  logic [`PX_W-1:0] dt_in,
	output px_bus_pins_t     pins,
	output px_bus_resp_t     resp
);

	localparam int CW = $clog2(`PX_ALARM_TICKS + 1);

	typedef enum logic [1:0] {
		B_IDLE,	// Waiting for a buffered request
		B_REQ,	// zg high, waiting for zw
		B_ACC,	// r or w high, waiting for ok
		B_REL	// Everything down, response out
	} phase_e;

	phase_e           phase;
	px_bus_req_t      cur;	// Request being served
	logic             zg_q;
	logic             r_q;
	logic             w_q;
	logic [CW-1:0]    ticks;	// No-answer counter
	logic             timeout;
	logic             resp_valid;
	logic             resp_alarm;
	logic [`PX_W-1:0] rd_data;

	assign pop     = (phase == B_IDLE) & ~empty;	// Take head as soon as idle
	assign timeout = (ticks == CW'(`PX_ALARM_TICKS - 1));

	assign pins.zg     = zg_q;
	assign pins.r      = r_q;
	assign pins.w      = w_q;
	assign pins.ad     = cur.addr;	// Held from pop to release
	assign pins.dt_out = cur.data;

	assign resp.valid = resp_valid;
	assign resp.alarm = resp_alarm;
	assign resp.data  = rd_data;

	// Latched request and read data
	always_ff @(posedge got) begin
		if (pop)
			cur <= head;
		if ((phase == B_ACC) && ok)
			rd_data <= dt_in;	// Captured with ok
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			phase      <= B_IDLE;
			zg_q       <= 1'b0;
			r_q        <= 1'b0;
			w_q        <= 1'b0;
			ticks      <= '0;
			resp_valid <= 1'b0;
			resp_alarm <= 1'b0;
		end else begin
			resp_valid <= 1'b0;	// Pulse by default off
			resp_alarm <= 1'b0;
			case (phase)
				B_IDLE: begin
					if (pop) begin
						zg_q  <= 1'b1;	// Request next cycle
						phase <= B_REQ;
					end
				end
				B_REQ: begin
					if (zw) begin
						r_q   <= ~cur.write;	// Access starts on grant
						w_q   <= cur.write;
						ticks <= '0;
						phase <= B_ACC;
					end
				end
				B_ACC: begin
					if (ok || timeout) begin
						zg_q       <= 1'b0;	// Drop all together
						r_q        <= 1'b0;
						w_q        <= 1'b0;
						resp_valid <= ~cur.write | ~ok;	// Reads, or any timeout
						resp_alarm <= ~ok;
						phase      <= B_REL;
					end else begin
						ticks <= ticks + 1'b1;
					end
				end
				default: begin
					phase <= B_IDLE;	// Release lasts one cycle
				end
			endcase
		end
	end

endmodule

//--- px_seq.sv
`timescale 1ns/1ps
// Cycle sequencer of the state control unit
// Steps P1, K1, K2 and W, holds IC, IR and the accumulator,
// posts fetch, load and store requests and stops on HLT or bus alarm
`include "px_params.svh"

module px_seq import px_pkg::*; (
	input  logic         got,
	input  logic         clo_,
	input  logic         start,
	input  px_bus_resp_t resp,
	input  logic         full,
	output logic         push,
	output px_bus_req_t  req,
	output logic         hlt,
	output logic         awaria
);

	px_state_e        state;
	px_instr_u        ir;
	logic [`PX_W-1:0] ic;
	logic [`PX_W-1:0] acc;
	logic             issued;	// Request of this state already posted
	logic             ack;
	logic             alarm;
	logic [`PX_W-1:0] imm_ext;
	logic [`PX_W-1:0] mem_addr;

	assign ack      = resp.valid & ~resp.alarm;
	assign alarm    = resp.valid & resp.alarm;
	assign imm_ext  = {{(`PX_W - 12){ir.short.imm[11]}}, ir.short.imm};
	assign mem_addr = {{(`PX_W - 12){1'b0}}, ir.mem.addr};

	// One request per K1 or W visit, stalls while buffer full
	assign push      = ~full & ~issued & ((state == ST_K1) | (state == ST_W));
	assign req.write = (state == ST_W) & (ir.mem.op == OP_SW);
	assign req.addr  = (state == ST_K1) ? ic : mem_addr;	// Fetch from IC
	assign req.data  = acc;	// Store data

	assign hlt    = (state == ST_HLT);
	assign awaria = (state == ST_AWARIA);

	// Instruction register, loaded by the fetch answer
	always_ff @(posedge got) begin
		if ((state == ST_K1) && ack)
			ir <= resp.data;
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state  <= ST_P1;
			ic     <= '0;
			acc    <= '0;
			issued <= 1'b0;
		end else if (alarm) begin
			state  <= ST_AWARIA;	// Held until clear
			issued <= 1'b0;
		end else begin
			case (state)
				ST_P1: begin
					if (start)
						state <= ST_K1;
				end
				ST_K1: begin
					if (push)
						issued <= 1'b1;
					if (ack) begin
						ic     <= ic + 1'b1;
						issued <= 1'b0;
						state  <= ST_K2;
					end
				end
				ST_K2: begin
					case (ir.mem.op)
						OP_LI: begin
							acc   <= imm_ext;
							state <= ST_K1;
						end
						OP_AI: begin
							acc   <= acc + imm_ext;
							state <= ST_K1;
						end
						OP_LW, OP_SW: state <= ST_W;
						OP_HLT: state <= ST_HLT;
						default: state <= ST_K1;	// No-op
					endcase
				end
				ST_W: begin
					if (ir.mem.op == OP_SW) begin
						if (push)
							state <= ST_K1;	// Posted, no wait
					end else begin
						if (push)
							issued <= 1'b1;
						if (ack) begin
							acc    <= resp.data;	// Load result
							issued <= 1'b0;
							state  <= ST_K1;
						end
					end
				end
				ST_HLT, ST_AWARIA: begin
					state <= state;	// Only clo_ leaves
				end
				default: begin
					state <= ST_P1;
				end
			endcase
		end
	end

endmodule

//--- px_top.sv
`timescale 1ns/1ps
// State control unit top level
// Sequencer feeding the request buffer, drained by the system bus master
`include "px_params.svh"

module px_top import px_pkg::*; (
	input  logic             got,
	input  logic             clo_,
	input  logic             start,
	input  logic             zw,
	input  logic             ok,
	input  logic [`PX_W-1:0] dt_in,
	output px_bus_pins_t     pins,
	output logic             hlt,
	output logic             awaria
);

	px_bus_req_t  seq_req;	// Sequencer to buffer
	logic         push;
	logic         full;
	px_bus_req_t  head;	// Buffer to bus master
	logic         empty;
	logic         pop;
	px_bus_resp_t resp;	// Bus master to sequencer

	px_seq u_px_seq (
		.got    (got),
		.clo_   (clo_),
		.start  (start),
		.resp   (resp),
		.full   (full),
		.push   (push),
		.req    (seq_req),
		.hlt    (hlt),
		.awaria (awaria)
	);

	px_req_fifo u_px_req_fifo (
		.got   (got),
		.clo_  (clo_),
		.push  (push),
		.din   (seq_req),
		.pop   (pop),
		.dout  (head),
		.full  (full),
		.empty (empty)
	);

	px_bus u_px_bus (
		.got   (got),
		.clo_  (clo_),
		.head  (head),
		.empty (empty),
		.pop   (pop),
		.zw    (zw),
		.ok    (ok),
		.dt_in (dt_in),
		.pins  (pins),
		.resp  (resp)
	);

endmodule

//--- px_assert.sv
`timescale 1ns/1ps
// Bus protocol checks bound into the system bus master
// r and w exclusive, access only under zg and zw, ad and dt_out steady
module px_assert import px_pkg::*; (
	input logic         got,
	input logic         clo_,
	input logic         zw,
	input px_bus_pins_t pins
);

	int unsigned fail_count = 0;	// Failed protocol checks so far

	a_rw_excl: assert property (@(posedge got) disable iff (!clo_)
		!(pins.r && pins.w))
	else begin
		$error("r and w high together");
		fail_count++;
	end

	// Access only inside a granted request
	a_granted: assert property (@(posedge got) disable iff (!clo_)
		(pins.r || pins.w) |-> (pins.zg && zw))
	else begin
		$error("r or w high without zg and zw");
		fail_count++;
	end

	a_steady: assert property (@(posedge got) disable iff (!clo_)
		((pins.r || pins.w) && $past(pins.r || pins.w)) |->
			($stable(pins.ad) && $stable(pins.dt_out)))
	else begin
		$error("ad or dt_out moved during an access");
		fail_count++;
	end

endmodule

//--- px_tb.sv
`timescale 1ns/1ps
// Testbench for the state control unit
// Memory model with random grant and answer delays, a reference
// interpreter predicting every bus access, and bound protocol checks
`include "px_params.svh"

module px_tb import px_pkg::*; ();

	localparam int MAX_STEPS = 32;	// Instructions per test at most
	localparam int WORST_ACCESS = 3 + 5 + `PX_ALARM_TICKS + 8;	// Slowest access in cycles
	localparam int WAIT_CYCLES = 2 * MAX_STEPS * WORST_ACCESS;
	localparam int NUM_TESTS = 4;
	localparam longint WATCHDOG_NS = NUM_TESTS * (WAIT_CYCLES + 64) * 8;
	localparam logic [`PX_W-1:0] NO_ANSWER = 16'd3840;	// Never answered from here up

	logic             got = 1'b0;
	logic             clo_ = 1'b0;
	logic             start = 1'b0;
	logic             zw = 1'b0;
	logic             ok = 1'b0;
	logic [`PX_W-1:0] dt_in = '0;
	px_bus_pins_t     pins;
	logic             hlt;
	logic             awaria;

	logic [`PX_W-1:0] prog [4096];	// Program image of the test
	logic [`PX_W-1:0] mem [4096];	// Live memory, reloaded in reset
	px_bus_req_t      exp_acc [$];	// Predicted bus accesses
	px_bus_req_t      cur_exp;
	int               exp_idx = 0;
	logic             end_alarm = 1'b0;	// Program ends on no answer
	logic             slow = 1'b0;	// Longest delays every time
	logic [31:0]      lfsr = 32'd32;
	int               zw_wait = 0;
	int               ok_wait = 0;
	int               acc_cycles = 0;
	logic             zw_armed = 1'b0;
	logic             ok_armed = 1'b0;
	int               seq_errors = 0;
	int               mon_errors = 0;
	int               tests = 0;

	px_top u_px_top (
		.got    (got),
		.clo_   (clo_),
		.start  (start),
		.zw     (zw),
		.ok     (ok),
		.dt_in  (dt_in),
		.pins   (pins),
		.hlt    (hlt),
		.awaria (awaria)
	);

	bind px_bus px_assert u_px_assert (
		.got  (got),
		.clo_ (clo_),
		.zw   (zw),
		.pins (pins)
	);

	always #4 got = ~got;	// 8 ns period

	// Galois LFSR, one step per bit taken
	function automatic int take_bits(input int nbits);
		int v;
		int i;
		v = 0;
		for (i = 0; i < nbits; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int total_errors();
		return seq_errors + mon_errors + int'(u_px_top.u_px_bus.u_px_assert.fail_count);
	endfunction

	// Memory model and bus access monitor
	always @(posedge got) begin
		if (!clo_) begin
			zw         <= 1'b0;
			ok         <= 1'b0;
			dt_in      <= '0;
			zw_armed   = 1'b0;
			ok_armed   = 1'b0;
			acc_cycles = 0;
			exp_idx    <= 0;
			mem        = prog;
		end else begin
			if (!pins.zg) begin
				zw       <= 1'b0;	// Grant follows zg down
				zw_armed = 1'b0;
			end else if (!zw) begin
				if (!zw_armed) begin
					zw_wait  = slow ? 3 : take_bits(2);	// 0 to 3 cycles
					zw_armed = 1'b1;
				end
				if (zw_wait == 0)
					zw <= 1'b1;
				else
					zw_wait--;
			end
			if (!(pins.r || pins.w)) begin
				if (ok_armed)
					assert (acc_cycles <= `PX_ALARM_TICKS + 2) else begin
						$display("access at %0t held r or w for %0d cycles", $time, acc_cycles);
						mon_errors++;
					end
				ok         <= 1'b0;	// ok held until r or w falls
				ok_armed   = 1'b0;
				acc_cycles = 0;
			end else begin
				if (!ok_armed) begin
					ok_wait  = slow ? 5 : take_bits(3) % 6;	// 0 to 5 cycles
					ok_armed = 1'b1;
					if (exp_idx >= exp_acc.size()) begin
						$display("unexpected bus access at %0t to address %h", $time, pins.ad);
						mon_errors++;
					end else begin
						cur_exp = exp_acc[exp_idx];
						assert (pins.w === cur_exp.write) else begin
							$display("error at %0t: pins.w expected %b got %b",
								$time, cur_exp.write, pins.w);
							mon_errors++;
						end
						assert (pins.ad === cur_exp.addr) else begin
							$display("error at %0t: pins.ad expected %h got %h",
								$time, cur_exp.addr, pins.ad);
							mon_errors++;
						end
						if (cur_exp.write)
							assert (pins.dt_out === cur_exp.data) else begin
								$display("error at %0t: pins.dt_out expected %h got %h",
									$time, cur_exp.data, pins.dt_out);
								mon_errors++;
							end
						exp_idx <= exp_idx + 1;
					end
				end
				acc_cycles++;
				if (!ok && (pins.ad < NO_ANSWER)) begin
					if (ok_wait == 0) begin
						ok <= 1'b1;
						if (pins.w)
							mem[pins.ad[11:0]] = pins.dt_out;
						else
							dt_in <= mem[pins.ad[11:0]];	// Data comes with ok
					end else begin
						ok_wait--;
					end
				end
			end
		end
	end

	function automatic logic [`PX_W-1:0] word(input logic [3:0] op, input logic [11:0] field);
		return {op, field};
	endfunction

	task automatic clear_prog();
		int a;
		for (a = 0; a < 4096; a++)
			prog[a] = ~16'(a);	// Address dependent fill
	endtask

	// Reference interpreter, one predicted access per bus cycle
	task automatic predict();
		logic [`PX_W-1:0] rm [4096];
		logic [`PX_W-1:0] pc;
		logic [`PX_W-1:0] a;
		logic [`PX_W-1:0] sx;
		logic [`PX_W-1:0] ea;
		px_instr_u        ins;
		int               step;
		rm = prog;
		pc = '0;
		a = '0;
		exp_acc.delete();
		end_alarm = 1'b0;
		for (step = 0; step < MAX_STEPS; step++) begin
			ins = rm[pc[11:0]];
			exp_acc.push_back(px_bus_req_t'{1'b0, pc, a});	// Fetch
			pc = pc + 1'b1;
			sx = {{4{ins.short.imm[11]}}, ins.short.imm};
			ea = 16'(ins.mem.addr);
			if (ins.mem.op == OP_HLT)
				break;
			case (ins.mem.op)
				OP_LI: a = sx;
				OP_AI: a = a + sx;
				OP_LW: begin
					exp_acc.push_back(px_bus_req_t'{1'b0, ea, a});
					if (ea >= NO_ANSWER) begin
						end_alarm = 1'b1;
						break;
					end
					a = rm[ea[11:0]];
				end
				OP_SW: begin
					exp_acc.push_back(px_bus_req_t'{1'b1, ea, a});
					rm[ea[11:0]] = a;
				end
				default: ;	// No-op
			endcase
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			$display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
			seq_errors++;
		end
	endtask

	task automatic do_reset();
		@(posedge got);
		clo_  <= 1'b0;
		start <= 1'b0;
		repeat (16) @(posedge got);
		clo_ <= 1'b1;
		@(posedge got);
	endtask

	task automatic reset_test();
		int errs_before;
		errs_before = total_errors();
		clear_prog();
		do_reset();
		repeat (12) begin
			@(negedge got);
			check_bit("pins.zg", pins.zg, 1'b0);
			check_bit("pins.r", pins.r, 1'b0);
			check_bit("pins.w", pins.w, 1'b0);
			check_bit("hlt", hlt, 1'b0);
			check_bit("awaria", awaria, 1'b0);
		end
		tests++;
		$display("test reset_idle done, %0d errors", total_errors() - errs_before);
	endtask

	task automatic run_test(input string name, input logic is_slow);
		int errs_before;
		int n;
		errs_before = total_errors();
		slow = is_slow;
		predict();
		do_reset();
		start <= 1'b1;	// Start pulse, P1 to K1
		@(posedge got);
		start <= 1'b0;
		for (n = 0; (n < WAIT_CYCLES) && !hlt && !awaria; n++)
			@(negedge got);
		assert (hlt || awaria) else begin
			$display("%s: processor neither halted nor raised awaria", name);
			seq_errors++;
		end
		check_bit("hlt", hlt, !end_alarm);
		check_bit("awaria", awaria, end_alarm);
		repeat (20) begin
			@(negedge got);
			check_bit("pins.zg", pins.zg, 1'b0);	// Bus stays quiet
		end
		assert (exp_idx == exp_acc.size()) else begin
			$display("%s: %0d of %0d predicted bus accesses seen", name, exp_idx, exp_acc.size());
			seq_errors++;
		end
		tests++;
		$display("test %s done, %0d errors", name, total_errors() - errs_before);
	endtask

	initial begin
		int i;
		reset_test();
		clear_prog();
		prog[0]  = word(OP_LI, 12'd5);
		prog[1]  = word(OP_AI, 12'hffd);	// Minus 3
		prog[2]  = word(OP_SW, 12'h100);
		prog[3]  = word(OP_LW, 12'h080);	// Fill word
		prog[4]  = word(OP_AI, 12'd7);
		prog[5]  = word(OP_SW, 12'h101);
		prog[6]  = word(OP_LW, 12'h100);	// Reads back the store
		prog[7]  = word(4'd0, 12'd0);
		prog[8]  = word(OP_AI, 12'd1);
		prog[9]  = word(OP_SW, 12'h102);
		prog[10] = word(OP_HLT, 12'd0);
		run_test("alu_load_store", 1'b0);
		clear_prog();
		prog[0] = word(OP_LI, 12'h123);
		for (i = 0; i < 8; i++)
			prog[1 + i] = word(OP_SW, 12'h200 + 12'(i));	// Back to back stores
		prog[9]  = word(OP_AI, 12'd5);
		prog[10] = word(OP_SW, 12'h208);
		prog[11] = word(OP_HLT, 12'd0);
		run_test("store_run_slow_bus", 1'b1);
		clear_prog();
		prog[0] = word(OP_LI, 12'd9);
		prog[1] = word(OP_SW, 12'h300);
		prog[2] = word(OP_LW, 12'hf00);	// Nobody answers
		prog[3] = word(OP_LI, 12'd1);
		run_test("no_answer_alarm", 1'b0);
		$display("tests run %0d, failed checks %0d", tests, total_errors());
		if (total_errors() == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
px_pkg.sv
px_req_fifo.sv
px_bus.sv
px_seq.sv
px_top.sv
px_assert.sv
px_tb.sv

//--- Makefile
# Verilator build and run for the state control unit testbench

VERILATOR ?= verilator
TOP       ?= px_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
